// File: lcd_geom_pkg.sv
package lcd_geom_pkg;

	// ------------------------------
	// raster coordinates
	// ------------------------------

	// wide enough for panels up to 4095 pixels on a side
	localparam int coord_w = 12;

	typedef logic [coord_w-1:0] coord_t;

	// one beat per visible pixel, in raster order
	typedef struct packed {
		logic   sof;	// first pixel of a frame, x=0 and y=0
		logic   eol;	// last pixel of a line
		coord_t x;
		coord_t y;
	} coord_beat_t;

endpackage

// File: lcd_color_pkg.sv
package lcd_color_pkg;

	// ------------------------------
	// colour and pixel types
	// ------------------------------

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// bar colours, in bar order
	localparam rgb_t color_red    = 24'hff0000;
	localparam rgb_t color_green  = 24'h00ff00;
	localparam rgb_t color_blue   = 24'h0000ff;
	localparam rgb_t color_white  = 24'hffffff;
	localparam rgb_t color_black  = 24'h000000;
	localparam rgb_t color_yellow = 24'hffff00;
	localparam rgb_t color_cyan   = 24'h00ffff;
	localparam rgb_t color_royal  = 24'h4169e1;

	function automatic rgb_t bar_color(input logic [2:0] idx);
		rgb_t c;
		case (idx)
			3'd0: c = color_red;
			3'd1: c = color_green;
			3'd2: c = color_blue;
			3'd3: c = color_white;
			3'd4: c = color_black;
			3'd5: c = color_yellow;
			3'd6: c = color_cyan;
			default: c = color_royal;
		endcase
		return c;
	endfunction

	typedef enum logic [1:0] {
		pat_hbars   = 2'd0,
		pat_vbars   = 2'd1,
		pat_product = 2'd2,
		pat_gray    = 2'd3
	} pattern_t;

	// command word, sampled at each start of frame
	typedef struct packed {
		logic     auto_cycle;	// step through all patterns
		pattern_t sel;			// manual pattern, or auto start point
	} pattern_cmd_t;

	typedef struct packed {
		logic sof;
		logic eol;
		rgb_t rgb;
	} pixel_beat_t;

endpackage

// File: pipe_stage.sv
`timescale 1ns/1ps

// single register slice on a valid/ready link
module pipe_stage
#(
	parameter type payload_t = logic
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic accept;

	// empty, or draining this cycle
	assign in_ready = !out_valid || out_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;	// beat left, nothing new
	end

	// payload held while stalled
	always_ff @(posedge clk)
	begin
		if (accept)
			out_data <= in_data;
	end

endmodule

// File: lcd_scan_gen.sv
`timescale 1ns/1ps

// walks the visible raster, one coordinate beat per transfer
module lcd_scan_gen
#(
	parameter int H_DISP = 480,
	parameter int V_DISP = 272
)
(
	input  logic                      clk,
	input  logic                      rst_n,
	output logic                      out_valid,
	input  logic                      out_ready,
	output lcd_geom_pkg::coord_beat_t out_data
);

	import lcd_geom_pkg::*;

	localparam coord_t x_last = coord_t'(H_DISP - 1);
	localparam coord_t y_last = coord_t'(V_DISP - 1);

	coord_t x;
	coord_t y;
	logic   step;

	assign step = out_valid && out_ready;

	// ------------------------------
	// valid comes up once after reset
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= 1'b1;
	end

	// ------------------------------
	// raster counters
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			x <= '0;
			y <= '0;
		end
		else if (step)
		begin
			if (x == x_last)
			begin
				x <= '0;
				// next line, or back to the top
				if (y == y_last)
					y <= '0;
				else
					y <= y + coord_t'(1);
			end
			else
				x <= x + coord_t'(1);
		end
	end

	// flags decoded straight from the counters
	always_comb
	begin
		out_data.sof = (x == '0) && (y == '0);
		out_data.eol = (x == x_last);
		out_data.x   = x;
		out_data.y   = y;
	end

endmodule

// File: lcd_pattern_gen.sv
`timescale 1ns/1ps

// picks a pattern per frame and turns each coordinate into a colour
module lcd_pattern_gen
#(
	parameter int H_DISP           = 480,
	parameter int V_DISP           = 272,
	parameter int FRAMES_PER_IMAGE = 30
)
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  lcd_color_pkg::pattern_cmd_t cmd,
	input  logic                       in_valid,
	output logic                       in_ready,
	input  lcd_geom_pkg::coord_beat_t  in_data,
	output logic                       out_valid,
	input  logic                       out_ready,
	output lcd_color_pkg::pixel_beat_t out_data
);

	import lcd_geom_pkg::*;
	import lcd_color_pkg::*;

	localparam int fcnt_w = $clog2(FRAMES_PER_IMAGE + 1);
	localparam logic [fcnt_w-1:0] fcnt_last = fcnt_w'(FRAMES_PER_IMAGE);
	localparam coord_t h_bar  = coord_t'(H_DISP / 8);
	localparam coord_t v_bar  = coord_t'(V_DISP / 8);
	localparam coord_t v_half = coord_t'(V_DISP / 2);

	logic              accept;
	logic              sof_accept;
	logic              auto_q;		// auto_cycle as seen at the last sof
	logic [fcnt_w-1:0] frame_cnt;	// frames shown of the current image
	logic [fcnt_w-1:0] next_cnt;
	pattern_t          frame_pat;
	pattern_t          next_pat;
	pattern_t          pat_sel;
	coord_t            hbar_idx;
	coord_t            vbar_idx;
	logic [2*coord_w-1:0] prod;
	rgb_t              rgb;

	assign in_ready   = !out_valid || out_ready;
	assign accept     = in_valid && in_ready;
	assign sof_accept = accept && in_data.sof;

	// ------------------------------
	// pattern for the next frame
	// ------------------------------

	always_comb
	begin
		if (!cmd.auto_cycle)
		begin
			next_pat = cmd.sel;
			next_cnt = '0;
		end
		else if (!auto_q)
		begin
			// auto mode just switched on, start from sel
			next_pat = cmd.sel;
			next_cnt = fcnt_w'(1);
		end
		else if (frame_cnt == fcnt_last)
		begin
			next_pat = pattern_t'(frame_pat + 2'd1);	// wraps 3 -> 0
			next_cnt = fcnt_w'(1);
		end
		else
		begin
			next_pat = frame_pat;
			next_cnt = frame_cnt + fcnt_w'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			auto_q    <= 1'b0;
			frame_cnt <= '0;
			frame_pat <= pat_hbars;
		end
		else if (sof_accept)
		begin
			auto_q    <= cmd.auto_cycle;
			frame_cnt <= next_cnt;
			frame_pat <= next_pat;
		end
	end

	// the sof beat already uses the new choice
	assign pat_sel = in_data.sof ? next_pat : frame_pat;

	// ------------------------------
	// colour per coordinate
	// ------------------------------

	assign hbar_idx = in_data.y / v_bar;
	assign vbar_idx = in_data.x / h_bar;
	assign prod     = in_data.x * in_data.y;

	always_comb
	begin
		case (pat_sel)
			pat_hbars:   rgb = bar_color(hbar_idx[2:0]);
			pat_vbars:   rgb = bar_color(vbar_idx[2:0]);
			pat_product: rgb = rgb_t'(prod[23:0]);
			default:
				if (in_data.y < v_half)
					rgb = {in_data.y[7:0], in_data.y[7:0], in_data.y[7:0]};
				else
					rgb = {in_data.x[7:0], in_data.x[7:0], in_data.x[7:0]};
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_data.sof <= in_data.sof;
			out_data.eol <= in_data.eol;
			out_data.rgb <= rgb;
		end
	end

endmodule

// File: lcd_pattern_top.sv
`timescale 1ns/1ps

// scan counter -> coord stage -> pattern gen -> pixel stage
module lcd_pattern_top
#(
	parameter int H_DISP           = 480,
	parameter int V_DISP           = 272,
	parameter int FRAMES_PER_IMAGE = 30
)
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  lcd_color_pkg::pattern_cmd_t cmd,
	output logic                        pix_valid,
	input  logic                        pix_ready,
	output lcd_color_pkg::pixel_beat_t  pix_data
);

	import lcd_geom_pkg::*;
	import lcd_color_pkg::*;

	// ------------------------------
	// coordinate side
	// ------------------------------

	logic        scan_valid;
	logic        scan_ready;
	coord_beat_t scan_data;
	logic        coord_valid;
	logic        coord_ready;
	coord_beat_t coord_data;

	// ------------------------------
	// colour side
	// ------------------------------

	logic        pat_valid;
	logic        pat_ready;
	pixel_beat_t pat_data;

	lcd_scan_gen #(
		.H_DISP (H_DISP),
		.V_DISP (V_DISP)
	) u_scan (
		.clk       (clk),
		.rst_n     (rst_n),
		.out_valid (scan_valid),
		.out_ready (scan_ready),
		.out_data  (scan_data)
	);

	pipe_stage #(
		.payload_t (coord_beat_t)
	) u_coord (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (scan_valid),
		.in_ready  (scan_ready),
		.in_data   (scan_data),
		.out_valid (coord_valid),
		.out_ready (coord_ready),
		.out_data  (coord_data)
	);

	lcd_pattern_gen #(
		.H_DISP           (H_DISP),
		.V_DISP           (V_DISP),
		.FRAMES_PER_IMAGE (FRAMES_PER_IMAGE)
	) u_pat (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.in_valid  (coord_valid),
		.in_ready  (coord_ready),
		.in_data   (coord_data),
		.out_valid (pat_valid),
		.out_ready (pat_ready),
		.out_data  (pat_data)
	);

	// output register towards the panel driver
	pipe_stage #(
		.payload_t (pixel_beat_t)
	) u_pixel (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (pat_valid),
		.in_ready  (pat_ready),
		.in_data   (pat_data),
		.out_valid (pix_valid),
		.out_ready (pix_ready),
		.out_data  (pix_data)
	);

endmodule

// File: lcd_pattern_asserts.sv
`timescale 1ns/1ps

// reference model of the pixel stream, checked by concurrent assertions
module lcd_pattern_asserts
#(
	parameter int H_DISP           = 480,
	parameter int V_DISP           = 272,
	parameter int FRAMES_PER_IMAGE = 30
)
(
	input logic                        clk,
	input logic                        rst_n,
	input lcd_color_pkg::pattern_cmd_t cmd,
	input logic                        coord_valid,
	input logic                        coord_ready,
	input lcd_geom_pkg::coord_beat_t   coord_data,
	input logic                        pix_valid,
	input logic                        pix_ready,
	input lcd_color_pkg::pixel_beat_t  pix_data
);

	import lcd_geom_pkg::*;
	import lcd_color_pkg::*;

	int          ex;				// tracked position of the next output beat
	int          ey;
	int          frames;			// frames shown of the current auto image
	logic        auto_seen;
	logic [1:0]  pend_pat;			// chosen at the last sof into the pattern gen
	logic [1:0]  cur_pat;			// pattern of the frame now leaving
	logic [1:0]  beat_pat;
	logic [23:0] exp_rgb;
	int          err_reset = 0;
	int          err_hold  = 0;
	int          err_sof   = 0;
	int          err_eol   = 0;
	int          err_color = 0;
	int          fail_cnt;

	assign fail_cnt = err_reset + err_hold + err_sof + err_eol + err_color;

	function automatic logic [23:0] bar_rgb(input int idx);
		case (idx)
			0: return 24'hff0000;
			1: return 24'h00ff00;
			2: return 24'h0000ff;
			3: return 24'hffffff;
			4: return 24'h000000;
			5: return 24'hffff00;
			6: return 24'h00ffff;
			default: return 24'h4169e1;	// royal
		endcase
	endfunction

	// ------------------------------
	// raster and pattern tracking
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex        <= 0;
			ey        <= 0;
			frames    <= 0;
			auto_seen <= 1'b0;
			pend_pat  <= 2'd0;
			cur_pat   <= 2'd0;
		end
		else
		begin
			if (pix_valid && pix_ready)
			begin
				if (ex == H_DISP - 1)
				begin
					ex <= 0;
					ey <= (ey == V_DISP - 1) ? 0 : ey + 1;
				end
				else
					ex <= ex + 1;
				if (ex == 0 && ey == 0)
					cur_pat <= pend_pat;	// new frame leaves
			end
			if (coord_valid && coord_ready && coord_data.sof)
			begin
				if (!cmd.auto_cycle)
				begin
					pend_pat  <= cmd.sel;
					auto_seen <= 1'b0;
				end
				else if (!auto_seen)
				begin
					pend_pat  <= cmd.sel;
					frames    <= 1;
					auto_seen <= 1'b1;
				end
				else if (frames == FRAMES_PER_IMAGE)
				begin
					pend_pat <= pend_pat + 2'd1;
					frames   <= 1;
				end
				else
					frames <= frames + 1;
			end
		end
	end

	always_comb
	begin
		beat_pat = (ex == 0 && ey == 0) ? pend_pat : cur_pat;
		case (beat_pat)
			2'd0: exp_rgb = bar_rgb(ey / (V_DISP / 8));
			2'd1: exp_rgb = bar_rgb(ex / (H_DISP / 8));
			2'd2: exp_rgb = 24'(ex * ey);
			default: exp_rgb = (ey < V_DISP / 2) ? {3{ey[7:0]}} : {3{ex[7:0]}};
		endcase
	end

	// ------------------------------
	// checks
	// ------------------------------

	a_reset_idle: assert property (@(posedge clk) !rst_n |-> !pix_valid)
		else begin err_reset++; $error("pix_valid is high while reset is asserted"); end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
		else begin err_hold++; $error("pixel beat changed or dropped while stalled"); end

	a_sof: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid |-> pix_data.sof == (ex == 0 && ey == 0))
		else begin err_sof++; $error("Fail sof at x=%0d y=%0d: expected %0d actual %0d",
			$sampled(ex), $sampled(ey), $sampled(ex == 0 && ey == 0), $sampled(pix_data.sof)); end

	a_eol: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid |-> pix_data.eol == (ex == H_DISP - 1))
		else begin err_eol++; $error("Fail eol at x=%0d y=%0d: expected %0d actual %0d",
			$sampled(ex), $sampled(ey), $sampled(ex == H_DISP - 1), $sampled(pix_data.eol)); end

	a_color: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid |-> pix_data.rgb == exp_rgb)
		else begin err_color++; $error("Fail colour at x=%0d y=%0d: expected %06h actual %06h",
			$sampled(ex), $sampled(ey), $sampled(exp_rgb), $sampled(pix_data.rgb)); end

endmodule

bind lcd_pattern_top lcd_pattern_asserts #(
	.H_DISP           (H_DISP),
	.V_DISP           (V_DISP),
	.FRAMES_PER_IMAGE (FRAMES_PER_IMAGE)
) u_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.cmd         (cmd),
	.coord_valid (coord_valid),
	.coord_ready (coord_ready),
	.coord_data  (coord_data),
	.pix_valid   (pix_valid),
	.pix_ready   (pix_ready),
	.pix_data    (pix_data)
);

// File: tb_lcd_pattern.sv
`timescale 1ns/1ps

module tb_lcd_pattern;

	import lcd_color_pkg::*;

	localparam int h_disp         = 32;
	localparam int v_disp         = 16;
	localparam int frame_beats    = h_disp * v_disp;
	localparam int frames_raster  = 1;
	localparam int frames_manual  = 8;		// two per pattern
	localparam int frames_change  = 2;
	localparam int frames_bp      = 2;
	localparam int frames_auto    = 10;		// one leftover frame, then nine auto frames
	localparam int total_frames   = frames_raster + frames_manual + frames_change
		+ frames_bp + frames_auto;
	localparam int cycle_limit    = total_frames * frame_beats * 3 + 200;

	logic         clk;
	logic         rst_n;
	pattern_cmd_t cmd;
	logic         pix_valid;
	logic         pix_ready;
	pixel_beat_t  pix_data;

	int          cycles    = 0;
	int          beat_cnt  = 0;		// accepted output beats
	int          sof_cnt   = 0;
	int          n_pass    = 0;
	int          n_fail    = 0;
	int          sof_start = 0;
	int          err_start = 0;
	logic [31:0] rng_state = 32'hc8c8_35a7;
	pattern_t    pat_list [4] = '{pat_hbars, pat_vbars, pat_product, pat_gray};

	lcd_pattern_top #(
		.H_DISP           (h_disp),
		.V_DISP           (v_disp),
		.FRAMES_PER_IMAGE (2)
	) dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.pix_data  (pix_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------
	// beat counting and watchdog
	// ------------------------------

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (pix_valid && pix_ready)
		begin
			beat_cnt <= beat_cnt + 1;
			if (pix_data.sof)
				sof_cnt <= sof_cnt + 1;
		end
		if (cycles == cycle_limit)
		begin
			$display("timeout: the pixel stream did not finish all tests in %0d cycles",
				cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// waits for n accepted beats, ready random or held high
	task automatic run_beats(input int n, input bit random_ready);
		int          target;
		logic [31:0] r;
		target = beat_cnt + n;
		while (beat_cnt < target)
		begin
			@(posedge clk);
			if (random_ready)
			begin
				r = next_random();
				pix_ready <= r[31];
			end
			else
				pix_ready <= 1'b1;
		end
	endtask

	task automatic begin_test();
		sof_start = sof_cnt;
		err_start = dut0.u_asserts.fail_cnt;
	endtask

	task automatic end_test(input string name, input int exp_frames);
		int frames;
		int errs;
		frames = sof_cnt - sof_start;
		errs   = dut0.u_asserts.fail_cnt - err_start;
		if (frames != exp_frames)
		begin
			$display("Fail %s: expected %0d frames, actual %0d", name, exp_frames, frames);
			n_fail++;
		end
		else if (errs != 0)
		begin
			$display("%s: %0d pixel checks went wrong during this test", name, errs);
			n_fail++;
		end
		else
		begin
			$display("%s: pass", name);
			n_pass++;
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial
	begin
		rst_n     <= 1'b0;
		pix_ready <= 1'b1;
		cmd       <= '{auto_cycle: 1'b0, sel: pat_hbars};

		// reset cycles belong to the raster test
		begin_test();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		run_beats(frames_raster * frame_beats, 1'b0);
		end_test("raster_order", frames_raster);

		begin_test();
		for (int i = 0; i < 4; i++)
		begin
			cmd <= '{auto_cycle: 1'b0, sel: pat_list[i]};
			run_beats(2 * frame_beats, 1'b0);
		end
		end_test("manual_patterns", frames_manual);

		// gray frame in flight, switch halfway through it
		begin_test();
		run_beats(frame_beats / 2, 1'b0);
		cmd <= '{auto_cycle: 1'b0, sel: pat_vbars};
		run_beats(frame_beats + frame_beats / 2, 1'b0);
		end_test("cmd_change_mid_frame", frames_change);

		begin_test();
		cmd <= '{auto_cycle: 1'b0, sel: pat_product};
		run_beats(frames_bp * frame_beats, 1'b1);
		end_test("back_pressure", frames_bp);

		begin_test();
		cmd <= '{auto_cycle: 1'b1, sel: pat_gray};
		run_beats(frames_auto * frame_beats, 1'b0);
		end_test("auto_cycle", frames_auto);

		$display("tests: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: sim.f
lcd_geom_pkg.sv
lcd_color_pkg.sv
pipe_stage.sv
lcd_scan_gen.sv
lcd_pattern_gen.sv
lcd_pattern_top.sv
lcd_pattern_asserts.sv
tb_lcd_pattern.sv

// File: Makefile
TOP := tb_lcd_pattern

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
